// ==== compile.f ====
+incdir+include
logic/core_pkg.sv
logic/inst_buffer.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/core_top.sv
verification/core_props.sv
verification/core_tb.sv

// ==== Bender.yml ====
package:
  name: core

sources:
  - include_dirs:
      - include
    files:
      - logic/core_pkg.sv
      - logic/inst_buffer.sv
      - logic/decode_stage.sv
      - logic/reg_file.sv
      - logic/execute_stage.sv
      - logic/result_stage.sv
      - logic/core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/core_props.sv
      - verification/core_tb.sv

// ==== verification/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module core_tb;

    localparam int RANDOM_WORDS    = 300;
    localparam int TRAILING_WORDS  = 3;     // sent after the ecall and never committed
    localparam int TOTAL_WORDS     = RANDOM_WORDS + 100;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 6 + 100;

    logic                                   clock;
    logic                                   reset;
    core_pkg::inst_word [`CORE_IN_WIDTH-1:0] in_insts;
    core_pkg::in_count                      num_input;
    core_pkg::ib_count                      ib_open;
    core_pkg::addr_word                     npc;
    core_pkg::commit_packet                 commit;

    core_pkg::inst_word program_q [$];
    core_pkg::inst_word sent_q [$];        // accepted words awaiting commit
    core_pkg::data_word model_regs [`CORE_REG_COUNT];
    core_pkg::addr_word model_pc;
    logic               halt_seen;
    int                 accepted;
    int                 errors  = 0;
    int                 checks  = 0;
    int                 commits = 0;

    core_top core_top_i (
        .clock     (clock),
        .reset     (reset),
        .in_insts  (in_insts),
        .num_input (num_input),
        .ib_open   (ib_open),
        .npc       (npc),
        .commit    (commit)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////
    // encoders and reference model
    //////////////////////////////

    function automatic core_pkg::inst_word enc_i(input logic [2:0] f3,
                                                 input core_pkg::reg_idx rd,
                                                 input core_pkg::reg_idx rs1,
                                                 input logic [11:0] imm);
        return {imm, rs1, f3, rd, `CORE_OPC_OP_IMM};
    endfunction

    function automatic core_pkg::inst_word enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                                 input core_pkg::reg_idx rd,
                                                 input core_pkg::reg_idx rs1,
                                                 input core_pkg::reg_idx rs2);
        return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
    endfunction

    function automatic core_pkg::inst_word enc_u(input core_pkg::reg_idx rd, input logic [19:0] imm);
        return {imm, rd, `CORE_OPC_LUI};
    endfunction

    // rv32i integer semantics where alt picks sub or sra
    function automatic core_pkg::data_word rv32_alu(input logic [2:0] f3, input logic alt,
                                                    input core_pkg::data_word a,
                                                    input core_pkg::data_word b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? core_pkg::data_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic core_pkg::commit_packet ref_commit(input core_pkg::inst_word inst,
                                                          input core_pkg::addr_word pc);
        core_pkg::commit_packet exp;
        logic [6:0]             f7;
        logic [2:0]             f3;
        core_pkg::data_word     a;
        core_pkg::data_word     b;
        f7 = inst[31:25];
        f3 = inst[14:12];
        a  = model_regs[inst[19:15]];
        b  = model_regs[inst[24:20]];
        exp       = '0;
        exp.valid = 1'b1;
        exp.pc    = pc;
        exp.dest  = inst[11:7];
        case (inst[6:0])
            `CORE_OPC_OP_IMM: begin
                exp.illegal = (f3 == 3'b001 && f7 != 7'h00) ||
                              (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
                exp.data = rv32_alu(f3, f3 == 3'b101 && f7 == 7'h20, a,
                                    {{20{inst[31]}}, inst[31:20]});
            end
            `CORE_OPC_OP: begin
                exp.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
                exp.data    = rv32_alu(f3, f7 == 7'h20, a, b);
            end
            `CORE_OPC_LUI:    exp.data = {inst[31:12], 12'b0};
            `CORE_OPC_SYSTEM: exp.halt = 1'b1;
            default:          exp.illegal = 1'b1;
        endcase
        return exp;
    endfunction

    function automatic core_pkg::inst_word rand_inst();
        int               kind;
        logic [2:0]       f3;
        logic [6:0]       f7;
        core_pkg::reg_idx rd;
        core_pkg::reg_idx rs1;
        core_pkg::reg_idx rs2;
        kind = $urandom_range(19, 0);
        f3   = 3'($urandom);
        rd   = 5'($urandom_range(7, 0));  // few registers give many dependencies
        rs1  = 5'($urandom_range(7, 0));
        rs2  = 5'($urandom_range(7, 0));
        f7   = ($urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
        if (kind < 8) begin
            if (f3 == 3'b001) begin
                return enc_i(f3, rd, rs1, {7'h00, 5'($urandom)});
            end else if (f3 == 3'b101) begin
                return enc_i(f3, rd, rs1, {f7, 5'($urandom)});
            end
            return enc_i(f3, rd, rs1, 12'($urandom));
        end else if (kind < 16) begin
            if (f3 != 3'b000 && f3 != 3'b101) begin
                f7 = 7'h00;
            end
            return enc_r(f7, f3, rd, rs1, rs2);
        end else if (kind < 18) begin
            return enc_u(rd, 20'($urandom));
        end else if (kind == 18) begin
            return enc_r(7'h01, f3, rd, rs1, rs2);  // m extension word
        end
        return {25'($urandom), 7'b0000011};  // load opcode
    endfunction

    //////////////////////////////
    // programs
    //////////////////////////////

    task automatic build_directed();
        program_q.delete();
        program_q.push_back(enc_i(3'b000, 1, 0, 12'd5));
        program_q.push_back(enc_i(3'b000, 2, 0, 12'hffd));   // x2 = -3
        program_q.push_back(enc_u(3, 20'h12345));
        program_q.push_back(enc_i(3'b010, 4, 2, 12'd1));
        program_q.push_back(enc_i(3'b011, 5, 2, 12'd1));
        program_q.push_back(enc_i(3'b100, 6, 1, 12'h0f0));
        program_q.push_back(enc_i(3'b110, 6, 6, 12'h801));
        program_q.push_back(enc_i(3'b111, 7, 3, 12'hfff));
        program_q.push_back(enc_i(3'b001, 7, 1, 12'd3));
        program_q.push_back(enc_i(3'b101, 8, 2, 12'd4));
        program_q.push_back(enc_i(3'b101, 9, 2, 12'h404));   // srai
        for (int f = 0; f < 8; f++) begin
            program_q.push_back(enc_r(7'h00, 3'(f), 5'(10 + f), 2, 1));
        end
        program_q.push_back(enc_r(7'h20, 3'b000, 18, 1, 2));  // sub
        program_q.push_back(enc_r(7'h20, 3'b101, 19, 2, 1));  // sra
        // chains at distance one, two and three
        program_q.push_back(enc_i(3'b000, 20, 1, 12'd7));
        program_q.push_back(enc_i(3'b000, 21, 20, 12'd1));
        program_q.push_back(enc_i(3'b000, 22, 20, 12'd2));
        program_q.push_back(enc_i(3'b000, 23, 20, 12'd3));
        program_q.push_back(enc_r(7'h00, 3'b000, 24, 23, 22));
        program_q.push_back(enc_i(3'b000, 0, 1, 12'd9));      // x0 write
        program_q.push_back(enc_r(7'h00, 3'b000, 25, 0, 1));
        program_q.push_back({12'h000, 5'd0, 3'b010, 5'd26, 7'b0000011});
        program_q.push_back(enc_r(7'h01, 3'b000, 26, 1, 2));
        program_q.push_back(enc_i(3'b001, 26, 1, 12'h403));
        program_q.push_back(enc_r(7'h00, 3'b000, 27, 26, 1)); // x26 still zero
    endtask

    task automatic build_random();
        program_q.delete();
        repeat (RANDOM_WORDS) program_q.push_back(rand_inst());
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
    endtask

    // bursts never exceed the free entries left after the last burst
    task automatic send_program(input logic full_rate);
        int idx;
        int avail;
        int burst;
        idx = 0;
        while (idx < program_q.size()) begin
            @(posedge clock);
            avail = int'(ib_open) - int'(num_input);
            burst = full_rate ? `CORE_IN_WIDTH : $urandom_range(`CORE_IN_WIDTH, 0);
            if (burst > avail) burst = (avail < 0) ? 0 : avail;
            if (burst > program_q.size() - idx) burst = program_q.size() - idx;
            for (int i = 0; i < `CORE_IN_WIDTH; i++) begin
                in_insts[i] <= (i < burst) ? program_q[idx + i] : '0;
            end
            num_input <= core_pkg::in_count'(burst);
            for (int i = 0; i < burst; i++) sent_q.push_back(program_q[idx + i]);
            idx      += burst;
            accepted += burst;
        end
        @(posedge clock);
        num_input <= '0;
    endtask

    task automatic run_phase(input logic full_rate);
        apply_reset();
        accepted = 0;
        @(posedge clock);
        if (ib_open !== core_pkg::ib_count'(`CORE_IB_DEPTH)) begin
            $display("Fail ib_open: got %h expected %h", ib_open, `CORE_IB_DEPTH);
            errors++;
        end
        if (npc !== '0) begin
            $display("Fail npc: got %h expected %h", npc, 32'h0);
            errors++;
        end
        program_q.push_back(32'h0000_0073);  // ecall
        repeat (TRAILING_WORDS) program_q.push_back(enc_i(3'b000, 1, 1, 12'd1));
        send_program(full_rate);
        while (!halt_seen) @(posedge clock);
        repeat (8) @(posedge clock);  // well past the three stage latency
        if (npc !== core_pkg::addr_word'(accepted * `CORE_PC_STEP)) begin
            $display("Fail npc: got %h expected %h", npc, accepted * `CORE_PC_STEP);
            errors++;
        end
        if (ib_open !== core_pkg::ib_count'(`CORE_IB_DEPTH - TRAILING_WORDS)) begin
            $display("Fail ib_open: got %h expected %h", ib_open,
                     `CORE_IB_DEPTH - TRAILING_WORDS);
            errors++;
        end
        if (sent_q.size() != TRAILING_WORDS) begin
            $display("%0d words left uncommitted at halt, expected %0d",
                     sent_q.size(), TRAILING_WORDS);
            errors++;
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, commits %0d, errors %0d", checks, commits, errors);
    endtask

    //////////////////////////////
    // compare
    //////////////////////////////

    always @(posedge clock) begin : compare_commits
        core_pkg::commit_packet exp;
        if (reset) begin
            sent_q.delete();
            model_pc  = '0;
            halt_seen = 1'b0;
            for (int i = 0; i < `CORE_REG_COUNT; i++) model_regs[i] = '0;
        end else if (commit.valid) begin
            commits++;
            if (halt_seen) begin
                $display("commit after halt at pc %h", commit.pc);
                errors++;
            end else if (sent_q.size() == 0) begin
                $display("extra commit at pc %h with no word outstanding", commit.pc);
                errors++;
            end else begin
                exp = ref_commit(sent_q.pop_front(), model_pc);
                checks++;
                if (commit.pc !== exp.pc) begin
                    $display("Fail commit.pc: got %h expected %h", commit.pc, exp.pc);
                    errors++;
                end
                if (commit.dest !== exp.dest) begin
                    $display("Fail commit.dest: got %h expected %h", commit.dest, exp.dest);
                    errors++;
                end
                if (commit.halt !== exp.halt) begin
                    $display("Fail commit.halt: got %h expected %h", commit.halt, exp.halt);
                    errors++;
                end
                if (commit.illegal !== exp.illegal) begin
                    $display("Fail commit.illegal: got %h expected %h", commit.illegal,
                             exp.illegal);
                    errors++;
                end
                if (!exp.halt && !exp.illegal && commit.data !== exp.data) begin
                    $display("Fail commit.data: got %h expected %h", commit.data, exp.data);
                    errors++;
                end
                if (!exp.halt && !exp.illegal && exp.dest != '0) begin
                    model_regs[exp.dest] = exp.data;
                end
                model_pc  = model_pc + `CORE_PC_STEP;
                halt_seen = exp.halt;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout after %0d cycles, halt never committed", WATCHDOG_CYCLES);
        report_counts();
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h2cbe313b));
        reset     = 1'b1;
        num_input = '0;
        in_insts  = '0;
        build_directed();
        run_phase(1'b1);   // back to back keeps the chain distances
        build_random();
        run_phase(1'b0);
        errors += core_top_i.core_props_i.prop_failures;
        report_counts();
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module core_props (
    input wire logic                   clock,
    input wire logic                   reset,
    input wire core_pkg::ib_count      ib_open,
    input wire core_pkg::commit_packet commit
);

    int   prop_failures = 0;
    logic halt_done;       // a halt has committed since reset

    always_ff @(posedge clock) begin
        if (reset) begin
            halt_done <= 1'b0;
        end else if (commit.valid && commit.halt) begin
            halt_done <= 1'b1;
        end
    end

    ib_open_in_range: assert property (@(posedge clock) disable iff (reset)
        ib_open <= `CORE_IB_DEPTH)
        else begin
            prop_failures++;
            $error("ib_open above buffer depth");
        end

    commit_idle_after_reset: assert property (@(posedge clock) reset |=> !commit.valid)
        else begin
            prop_failures++;
            $error("commit valid right after reset");
        end

    no_commit_after_halt: assert property (@(posedge clock) disable iff (reset)
        halt_done |-> !commit.valid)
        else begin
            prop_failures++;
            $error("commit after a halt commit");
        end

endmodule

bind core_top core_props core_props_i (
    .clock   (clock),
    .reset   (reset),
    .ib_open (ib_open),
    .commit  (commit)
);

`default_nettype wire

// ==== logic/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module core_top (
    input  wire logic                                clock,
    input  wire logic                                reset,
    input  wire core_pkg::inst_word [`CORE_IN_WIDTH-1:0] in_insts,
    input  wire core_pkg::in_count                   num_input,  // at most ib_open
    output core_pkg::ib_count                        ib_open,
    output core_pkg::addr_word                       npc,
    output core_pkg::commit_packet                   commit
);

    ////////////////////////////////
    // stage to stage wires
    ////////////////////////////////

    core_pkg::fetch_packet   fetch;
    core_pkg::decoded_packet decoded;
    core_pkg::result_packet  result;
    core_pkg::data_word      op1;
    core_pkg::data_word      op2;

    core_pkg::reg_idx        rs1_idx;
    core_pkg::reg_idx        rs2_idx;
    core_pkg::data_word      rs1_data;
    core_pkg::data_word      rs2_data;
    logic                    wr_en;
    core_pkg::reg_idx        wr_idx;
    core_pkg::data_word      wr_data;

    inst_buffer inst_buffer_i (
        .clock     (clock),
        .reset     (reset),
        .in_insts  (in_insts),
        .num_input (num_input),
        .fetch     (fetch),
        .ib_open   (ib_open),
        .npc       (npc)
    );

    decode_stage decode_stage_i (
        .clock    (clock),
        .reset    (reset),
        .fetch    (fetch),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .decoded  (decoded),
        .op1      (op1),
        .op2      (op2)
    );

    reg_file reg_file_i (
        .clock    (clock),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

    execute_stage execute_stage_i (
        .clock   (clock),
        .reset   (reset),
        .decoded (decoded),
        .op1     (op1),
        .op2     (op2),
        .result  (result)
    );

    result_stage result_stage_i (
        .clock   (clock),
        .reset   (reset),
        .result  (result),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .commit  (commit)
    );

endmodule

`default_nettype wire

// ==== logic/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire core_pkg::result_packet result,
    output logic                        wr_en,
    output core_pkg::reg_idx            wr_idx,
    output core_pkg::data_word          wr_data,
    output core_pkg::commit_packet      commit
);

    // register write lands at the same edge as the commit
    assign wr_en   = result.valid && result.writes_reg;
    assign wr_idx  = result.dest;
    assign wr_data = result.value;

    always_ff @(posedge clock) begin
        if (reset) begin
            commit <= '0;
        end else begin
            commit.valid   <= result.valid;   // illegal and halt commit too
            commit.pc      <= result.pc;
            commit.dest    <= result.dest;
            commit.data    <= result.value;
            commit.halt    <= result.halt;
            commit.illegal <= result.illegal;
        end
    end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire core_pkg::decoded_packet decoded,
    input  wire core_pkg::data_word      op1,
    input  wire core_pkg::data_word      op2,
    output core_pkg::result_packet       result
);

    logic                   fwd1;
    logic                   fwd2;
    core_pkg::data_word     src_a;
    core_pkg::data_word     src_b;
    core_pkg::data_word     alu_b;
    core_pkg::data_word     alu_out;
    logic [4:0]             shamt;
    core_pkg::result_packet res_next;

    ////////////////////////////////
    // operand select
    ////////////////////////////////

    // previous instruction sits in the result register
    assign fwd1 = result.valid && result.writes_reg && (result.dest == decoded.src1);
    assign fwd2 = result.valid && result.writes_reg && (result.dest == decoded.src2);

    assign src_a = fwd1 ? result.value : op1;
    assign src_b = fwd2 ? result.value : op2;
    assign alu_b = decoded.use_imm ? decoded.imm : src_b;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (decoded.op)
            core_pkg::alu_add:  alu_out = src_a + alu_b;
            core_pkg::alu_sub:  alu_out = src_a - alu_b;
            core_pkg::alu_sll:  alu_out = src_a << shamt;
            core_pkg::alu_slt:  alu_out = {31'b0, $signed(src_a) < $signed(alu_b)};
            core_pkg::alu_sltu: alu_out = {31'b0, src_a < alu_b};
            core_pkg::alu_xor:  alu_out = src_a ^ alu_b;
            core_pkg::alu_srl:  alu_out = src_a >> shamt;
            core_pkg::alu_sra:  alu_out = $unsigned($signed(src_a) >>> shamt);
            core_pkg::alu_or:   alu_out = src_a | alu_b;
            core_pkg::alu_and:  alu_out = src_a & alu_b;
            default:            alu_out = alu_b;  // pass immediate
        endcase
    end

    always_comb begin
        res_next.valid      = decoded.valid;
        res_next.pc         = decoded.pc;
        res_next.dest       = decoded.dest;
        res_next.writes_reg = decoded.writes_reg;
        res_next.value      = alu_out;
        res_next.halt       = decoded.halt;
        res_next.illegal    = decoded.illegal;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= res_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module reg_file (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire core_pkg::reg_idx   rs1_idx,
    input  wire core_pkg::reg_idx   rs2_idx,
    output core_pkg::data_word      rs1_data,
    output core_pkg::data_word      rs2_data,
    input  wire logic               wr_en,
    input  wire core_pkg::reg_idx   wr_idx,
    input  wire core_pkg::data_word wr_data
);

    core_pkg::data_word regs [1:`CORE_REG_COUNT-1];  // x0 has no storage

    // a same-cycle write wins over the stored value
    function automatic core_pkg::data_word read_port(input core_pkg::reg_idx idx);
        if (idx == '0) begin
            return '0;
        end else if (wr_en && wr_idx == idx) begin
            return wr_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module decode_stage (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire core_pkg::fetch_packet fetch,
    output core_pkg::reg_idx           rs1_idx,
    output core_pkg::reg_idx           rs2_idx,
    input  wire core_pkg::data_word    rs1_data,
    input  wire core_pkg::data_word    rs2_data,
    output core_pkg::decoded_packet    decoded,
    output core_pkg::data_word         op1,
    output core_pkg::data_word         op2
);

    core_pkg::inst_word      inst;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    core_pkg::decoded_packet dec_next;

    assign inst    = fetch.inst;
    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];

    // funct3 meaning shared by op and op-imm
    function automatic core_pkg::alu_op base_op(input logic [2:0] f3);
        case (f3)
            3'b000:  return core_pkg::alu_add;
            3'b001:  return core_pkg::alu_sll;
            3'b010:  return core_pkg::alu_slt;
            3'b011:  return core_pkg::alu_sltu;
            3'b100:  return core_pkg::alu_xor;
            3'b101:  return core_pkg::alu_srl;
            3'b110:  return core_pkg::alu_or;
            default: return core_pkg::alu_and;
        endcase
    endfunction

    ////////////////////////////////
    // field decode
    ////////////////////////////////

    always_comb begin
        dec_next       = '0;
        dec_next.valid = fetch.valid;
        dec_next.pc    = fetch.pc;
        dec_next.dest  = inst[11:7];
        dec_next.src1  = rs1_idx;
        dec_next.src2  = rs2_idx;
        dec_next.op    = base_op(funct3);
        case (opcode)
            `CORE_OPC_OP_IMM: begin
                dec_next.use_imm = 1'b1;
                dec_next.imm     = {{20{inst[31]}}, inst[31:20]};
                if (funct3 == 3'b001) begin
                    dec_next.illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    if (funct7 == `CORE_FUNCT7_ALT) begin
                        dec_next.op = core_pkg::alu_sra;
                    end else begin
                        dec_next.illegal = (funct7 != 7'b0000000);
                    end
                end
            end
            `CORE_OPC_OP: begin
                if (funct7 == `CORE_FUNCT7_ALT && funct3 == 3'b000) begin
                    dec_next.op = core_pkg::alu_sub;
                end else if (funct7 == `CORE_FUNCT7_ALT && funct3 == 3'b101) begin
                    dec_next.op = core_pkg::alu_sra;
                end else begin
                    dec_next.illegal = (funct7 != 7'b0000000);  // no m extension
                end
            end
            `CORE_OPC_LUI: begin
                dec_next.op      = core_pkg::alu_pass;
                dec_next.use_imm = 1'b1;
                dec_next.imm     = {inst[31:12], 12'b0};
            end
            `CORE_OPC_SYSTEM: dec_next.halt = 1'b1;  // ecall stops the core
            default:          dec_next.illegal = 1'b1;
        endcase
        dec_next.writes_reg = fetch.valid && !dec_next.illegal && !dec_next.halt &&
                              (dec_next.dest != '0);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            decoded <= '0;
        end else begin
            decoded <= dec_next;
        end
    end

    // operand values travel beside the packet
    always_ff @(posedge clock) begin
        op1 <= rs1_data;
        op2 <= rs2_data;
    end

endmodule

`default_nettype wire

// ==== logic/inst_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module inst_buffer (
    input  wire logic                                clock,
    input  wire logic                                reset,
    input  wire core_pkg::inst_word [`CORE_IN_WIDTH-1:0] in_insts,  // word 0 is oldest
    input  wire core_pkg::in_count                   num_input,
    output core_pkg::fetch_packet                    fetch,
    output core_pkg::ib_count                        ib_open,
    output core_pkg::addr_word                       npc
);

    core_pkg::fetch_packet queue [`CORE_IB_DEPTH];
    core_pkg::ib_ptr       head;
    core_pkg::ib_ptr       tail;
    core_pkg::ib_count     count;
    core_pkg::addr_word    pc;      // address of the next accepted word
    logic                  halted;
    logic                  pop;

    // head leaves every cycle it exists, nothing downstream stalls
    assign pop = (count != '0) && !halted;

    always_comb begin
        fetch       = queue[head];
        fetch.valid = pop;
    end

    assign ib_open = core_pkg::ib_count'(`CORE_IB_DEPTH) - count;
    assign npc     = pc;

    ////////////////////////////////
    // pointers, count, halt latch
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            tail  <= tail + core_pkg::ib_ptr'(num_input);
            head  <= head + core_pkg::ib_ptr'(pop);
            count <= count + core_pkg::ib_count'(num_input) - core_pkg::ib_count'(pop);
            pc    <= pc + core_pkg::addr_word'(num_input) * core_pkg::addr_word'(`CORE_PC_STEP);
            if (pop && fetch.inst[6:0] == `CORE_OPC_SYSTEM) begin
                halted <= 1'b1;  // sticky until reset
            end
        end
    end

    // entry storage, each word tagged with its own address
    always_ff @(posedge clock) begin
        for (int i = 0; i < `CORE_IN_WIDTH; i++) begin
            if (i < num_input) begin
                queue[core_pkg::ib_ptr'(tail + i)] <= '{
                    valid: 1'b1,
                    pc:    pc + core_pkg::addr_word'(i * `CORE_PC_STEP),
                    inst:  in_insts[i]
                };
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/core_pkg.sv ====
`include "core_config.svh"

`default_nettype none

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]      inst_word;
    typedef logic [`CORE_XLEN-1:0]      data_word;
    typedef logic [`CORE_XLEN-1:0]      addr_word;
    typedef logic [`CORE_REG_IDX_W-1:0] reg_idx;

    // buffer bookkeeping
    typedef logic [$clog2(`CORE_IB_DEPTH)-1:0]   ib_ptr;
    typedef logic [$clog2(`CORE_IB_DEPTH+1)-1:0] ib_count;
    typedef logic [$clog2(`CORE_IN_WIDTH+1)-1:0] in_count;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass    // lui, result is the immediate
    } alu_op;

    typedef struct packed {
        logic     valid;
        addr_word pc;
        inst_word inst;
    } fetch_packet;

    typedef struct packed {
        logic     valid;
        addr_word pc;
        alu_op    op;
        reg_idx   dest;
        reg_idx   src1;
        reg_idx   src2;
        logic     use_imm;
        data_word imm;
        logic     writes_reg;
        logic     halt;
        logic     illegal;
    } decoded_packet;

    typedef struct packed {
        logic     valid;
        addr_word pc;
        reg_idx   dest;
        logic     writes_reg;
        data_word value;
        logic     halt;
        logic     illegal;
    } result_packet;

    typedef struct packed {
        logic     valid;
        addr_word pc;
        reg_idx   dest;
        data_word data;
        logic     halt;
        logic     illegal;
    } commit_packet;

endpackage

`default_nettype wire

// ==== include/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath widths
`define CORE_XLEN       32
`define CORE_REG_COUNT  32
`define CORE_REG_IDX_W  5

// front end sizing
`define CORE_IN_WIDTH   2   // words accepted per cycle at most
`define CORE_IB_DEPTH   8
`define CORE_PC_STEP    4   // bytes per instruction word

// rv32i major opcodes that the core keeps
`define CORE_OPC_OP_IMM 7'b0010011
`define CORE_OPC_OP     7'b0110011
`define CORE_OPC_LUI    7'b0110111
`define CORE_OPC_SYSTEM 7'b1110011

`define CORE_FUNCT7_ALT 7'b0100000  // sub and sra

`endif
